// File: design/sem_pkg.sv
package sem_pkg;

	////////////////////////////////////////////////////////////////////
	// Widths with a meaning
	////////////////////////////////////////////////////////////////////

	typedef logic [7:0]  char_t;     // One monitor character
	typedef logic [7:0]  cmd_t;      // Command byte toward the core
	typedef logic [23:0] far_t;      // Frame address
	typedef logic [7:0]  err_cnt_t;  // Error counter
	typedef logic [15:0] status_t;   // Status word to the register file

	////////////////////////////////////////////////////////////////////
	// Monitor stream
	////////////////////////////////////////////////////////////////////

	localparam int MON_WINDOW = 9;   // Characters kept in the window
	localparam int HEX_DIGITS = 6;   // Digits in a frame address

	localparam char_t CHAR_SPACE = 8'h20;  // Window fill after reset

	// Error tokens, seen at the newest end of the window
	localparam logic [23:0] TOK_DED = "DED";
	localparam logic [23:0] TOK_SED = "SED";

	// Address prefixes with trailing space, seen at the oldest end
	localparam logic [23:0] TOK_PA = "PA ";
	localparam logic [23:0] TOK_LA = "LA ";

	////////////////////////////////////////////////////////////////////
	// Command FIFO
	////////////////////////////////////////////////////////////////////

	localparam int CMD_FIFO_DEPTH = 16;
	localparam int CMD_PTR_W      = 4;   // log2 of the depth

	// Status word layout
	localparam int ST_CRC_BIT = 8;   // CRC error from the core
	localparam int ST_DED_BIT = 9;   // Sticky double error

endpackage

// File: design/sem_event_if.sv
`timescale 1ns/1ps

// Token events from the monitor parser to the error log
interface sem_event_if;
	import sem_pkg::*;

	logic ded_evt;   // Double error seen
	logic sed_evt;   // Single error seen
	logic pa_load;   // Physical address ready in far_hex
	logic la_load;   // Linear address ready in far_hex
	far_t far_hex;   // Converted address

	modport parser_mp (
		output ded_evt, sed_evt, pa_load, la_load, far_hex
	);

	modport log_mp (
		input ded_evt, sed_evt, pa_load, la_load, far_hex
	);

endinterface

// File: design/sem_monitor_parser.sv
`timescale 1ns/1ps

module sem_monitor_parser (
	input  logic          CLK40,
	input  logic          RST,
	input  sem_pkg::char_t mon_txdata_i,   // Monitor byte from the core
	input  logic          mon_txwrite_i,  // Write strobe, one cycle
	sem_event_if.parser_mp evt
);
	import sem_pkg::*;

	char_t [MON_WINDOW-1:0] win_q;  // Index 0 is the newest character

	logic ded_hit, sed_hit, pa_hit, la_hit;
	logic ded_q, sed_q, pa_q, la_q;   // Previous match state
	logic pa_load_q, la_load_q;       // Aligned with conv_q
	far_t conv_q;

	// ASCII hex to nibble, letters have bit 6 set
	function automatic logic [3:0] hex_nibble(input char_t c);
		logic [3:0] val;
		val = c[6] ? c[3:0] + 4'd9 : c[3:0];
		return val;
	endfunction

	////////////////////////////////////////////////////////////////////
	// Character window
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			win_q <= {MON_WINDOW{CHAR_SPACE}};
		end else if (mon_txwrite_i) begin
			win_q <= {win_q[MON_WINDOW-2:0], mon_txdata_i};  // Shift in newest
		end
	end

	// Errors end the stream, prefixes sit before the six digits
	assign ded_hit = ({win_q[2], win_q[1], win_q[0]} == TOK_DED);
	assign sed_hit = ({win_q[2], win_q[1], win_q[0]} == TOK_SED);
	assign pa_hit  = ({win_q[MON_WINDOW-1], win_q[MON_WINDOW-2], win_q[MON_WINDOW-3]} == TOK_PA);
	assign la_hit  = ({win_q[MON_WINDOW-1], win_q[MON_WINDOW-2], win_q[MON_WINDOW-3]} == TOK_LA);

	////////////////////////////////////////////////////////////////////
	// Edge detection and address alignment
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			ded_q     <= 1'b0;
			sed_q     <= 1'b0;
			pa_q      <= 1'b0;
			la_q      <= 1'b0;
			pa_load_q <= 1'b0;
			la_load_q <= 1'b0;
		end else begin
			ded_q     <= ded_hit;
			sed_q     <= sed_hit;
			pa_q      <= pa_hit;
			la_q      <= la_hit;
			pa_load_q <= pa_hit & ~pa_q;  // Digits convert in the same edge
			la_load_q <= la_hit & ~la_q;
		end
	end

	// Hex conversion of the newest six characters, runs every cycle
	always_ff @(posedge CLK40) begin
		for (int i = 0; i < HEX_DIGITS; i++) begin
			conv_q[4*i +: 4] <= hex_nibble(win_q[i]);
		end
	end

	// First appearance of a token only
	assign evt.ded_evt = ded_hit & ~ded_q;
	assign evt.sed_evt = sed_hit & ~sed_q;
	assign evt.pa_load = pa_load_q;
	assign evt.la_load = la_load_q;
	assign evt.far_hex = conv_q;

endmodule

// File: design/sem_error_log.sv
`timescale 1ns/1ps

module sem_error_log (
	input  logic              CLK40,
	input  logic              RST,
	sem_event_if.log_mp       evt,
	input  logic              ded_clr_i,    // Clears flag and addresses
	input  logic              cnt_clr_i,    // Clears both counters
	output sem_pkg::err_cnt_t sngl_cnt_o,
	output sem_pkg::err_cnt_t dbl_cnt_o,
	output logic              dbl_err_o,    // Sticky double error
	output sem_pkg::far_t     far_pa_o,
	output sem_pkg::far_t     far_la_o
);
	import sem_pkg::*;

	////////////////////////////////////////////////////////////////////
	// Error counters
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			sngl_cnt_o <= '0;
			dbl_cnt_o  <= '0;
		end else if (cnt_clr_i) begin
			sngl_cnt_o <= '0;  // Clear beats increment
			dbl_cnt_o  <= '0;
		end else begin
			if (evt.sed_evt)
				sngl_cnt_o <= sngl_cnt_o + 1'b1;  // Wraps at 255
			if (evt.ded_evt)
				dbl_cnt_o <= dbl_cnt_o + 1'b1;
		end
	end

	// Double error flag, held until software clears it
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			dbl_err_o <= 1'b0;
		else if (ded_clr_i)
			dbl_err_o <= 1'b0;
		else if (evt.ded_evt)
			dbl_err_o <= 1'b1;
	end

	////////////////////////////////////////////////////////////////////
	// Frame address registers
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			far_pa_o <= '0;
			far_la_o <= '0;
		end else begin
			if (evt.pa_load)
				far_pa_o <= evt.far_hex;  // New address wins over clear
			else if (ded_clr_i)
				far_pa_o <= '0;

			if (evt.la_load)
				far_la_o <= evt.far_hex;
			else if (ded_clr_i)
				far_la_o <= '0;
		end
	end

endmodule

// File: design/sem_cmd_queue.sv
`timescale 1ns/1ps

module sem_cmd_queue (
	input  logic          CLK40,
	input  logic          RST,
	input  logic          jtag_take_i,      // Hand control back to JTAG
	input  logic          dbg_take_i,       // Debug port takes control
	input  sem_pkg::cmd_t jtag_cmd_data_i,
	input  logic          jtag_send_i,
	input  sem_pkg::cmd_t dbg_cmd_data_i,
	input  logic          dbg_send_i,
	input  logic          cmd_read_i,       // Core pops the head
	output sem_pkg::cmd_t cmd_data_o,       // Head entry, FWFT
	output logic          cmd_empty_o
);
	import sem_pkg::*;

	logic src_dbg_q;   // 1 while debug port owns the queue

	cmd_t wr_data;
	logic wr_req;
	logic push, pop;
	logic full;

	cmd_t                 mem [CMD_FIFO_DEPTH];
	logic [CMD_PTR_W-1:0] wr_ptr_q, rd_ptr_q;
	logic [CMD_PTR_W:0]   count_q;   // 0 to depth inclusive

	////////////////////////////////////////////////////////////////////
	// Source select
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST)
			src_dbg_q <= 1'b0;  // JTAG after reset
		else if (dbg_take_i)
			src_dbg_q <= 1'b1;  // Debug wins a tie
		else if (jtag_take_i)
			src_dbg_q <= 1'b0;
	end

	assign wr_data = src_dbg_q ? dbg_cmd_data_i : jtag_cmd_data_i;
	assign wr_req  = src_dbg_q ? dbg_send_i : jtag_send_i;

	////////////////////////////////////////////////////////////////////
	// Command FIFO
	////////////////////////////////////////////////////////////////////

	assign full        = count_q[CMD_PTR_W];  // Depth is a power of two
	assign cmd_empty_o = (count_q == '0);
	assign push        = wr_req & ~full;       // Dropped when full
	assign pop         = cmd_read_i & ~cmd_empty_o;

	always_ff @(posedge CLK40) begin
		if (push)
			mem[wr_ptr_q] <= wr_data;
	end

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;  // Pointers wrap naturally
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({push, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;   // Idle or push with pop
			endcase
		end
	end

	assign cmd_data_o = mem[rd_ptr_q];

endmodule

// File: design/sem_monitor_top.sv
`timescale 1ns/1ps

module sem_monitor_top (
	input  logic             CLK40,
	input  logic             RST,
	// Monitor stream from the core
	input  sem_pkg::char_t   mon_txdata_i,
	input  logic             mon_txwrite_i,
	// Core status
	input  logic [6:0]       core_status_i,
	input  logic             crc_err_i,
	// Register controls
	input  logic             ded_clr_i,
	input  logic             cnt_clr_i,
	// Command sources
	input  logic             jtag_take_i,
	input  sem_pkg::cmd_t    jtag_cmd_data_i,
	input  logic             jtag_send_i,
	input  logic             dbg_take_i,
	input  sem_pkg::cmd_t    dbg_cmd_data_i,
	input  logic             dbg_send_i,
	// Command queue toward the core
	input  logic             cmd_read_i,
	output sem_pkg::cmd_t    cmd_data_o,
	output logic             cmd_empty_o,
	// Results
	output sem_pkg::far_t    far_pa_o,
	output sem_pkg::far_t    far_la_o,
	output logic [15:0]      err_cnt_o,  // {double, single}
	output sem_pkg::status_t status_o
);
	import sem_pkg::*;

	err_cnt_t sngl_cnt, dbl_cnt;
	logic     dbl_err;

	sem_event_if evt_if ();

	////////////////////////////////////////////////////////////////////
	// Monitor input and error log
	////////////////////////////////////////////////////////////////////

	sem_monitor_parser u_parser (
		.CLK40         (CLK40),
		.RST           (RST),
		.mon_txdata_i  (mon_txdata_i),
		.mon_txwrite_i (mon_txwrite_i),
		.evt           (evt_if)
	);

	sem_error_log u_log (
		.CLK40      (CLK40),
		.RST        (RST),
		.evt        (evt_if),
		.ded_clr_i  (ded_clr_i),
		.cnt_clr_i  (cnt_clr_i),
		.sngl_cnt_o (sngl_cnt),
		.dbl_cnt_o  (dbl_cnt),
		.dbl_err_o  (dbl_err),
		.far_pa_o   (far_pa_o),
		.far_la_o   (far_la_o)
	);

	// Command path to the core
	sem_cmd_queue u_cmd_queue (
		.CLK40           (CLK40),
		.RST             (RST),
		.jtag_take_i     (jtag_take_i),
		.dbg_take_i      (dbg_take_i),
		.jtag_cmd_data_i (jtag_cmd_data_i),
		.jtag_send_i     (jtag_send_i),
		.dbg_cmd_data_i  (dbg_cmd_data_i),
		.dbg_send_i      (dbg_send_i),
		.cmd_read_i      (cmd_read_i),
		.cmd_data_o      (cmd_data_o),
		.cmd_empty_o     (cmd_empty_o)
	);

	assign err_cnt_o = {dbl_cnt, sngl_cnt};

	// Status word, unused bits read zero
	always_comb begin
		status_o             = '0;
		status_o[6:0]        = core_status_i;
		status_o[ST_CRC_BIT] = crc_err_i;
		status_o[ST_DED_BIT] = dbl_err;
	end

endmodule

// File: tb/tb_sem_monitor.sv
`timescale 1ns/1ps

module tb_sem_monitor;
	import sem_pkg::*;

	localparam int WAIT_MAX = 200;  // Cycles before a wait gives up

	typedef struct packed {
		err_cnt_t sngl;
		err_cnt_t dbl;
		far_t     pa;
		far_t     la;
	} ref_t;

	logic    CLK40 = 1'b0;
	logic    RST;
	char_t   mon_txdata_i;
	logic    mon_txwrite_i, crc_err_i, ded_clr_i, cnt_clr_i;
	logic    [6:0] core_status_i;
	logic    jtag_take_i, jtag_send_i, dbg_take_i, dbg_send_i, cmd_read_i;
	cmd_t    jtag_cmd_data_i, dbg_cmd_data_i, cmd_data_o;
	logic    cmd_empty_o;
	far_t    far_pa_o, far_la_o;
	logic    [15:0] err_cnt_o;
	status_t status_o;

	char_t sent_q[$];     // Every monitor character since reset
	cmd_t  exp_cmd_q[$];  // Commands the core should read in order
	int    rd_idx = 0;    // Reads seen by the compare process
	int    model_fill;    // Expected FIFO occupancy
	bit    src_dbg;       // Expected source select

	sem_monitor_top DUT (.*);

	always #20 CLK40 = ~CLK40;

	////////////////////////////////////////////////////////////////////
	// Reference model and compare tasks
	////////////////////////////////////////////////////////////////////

	function automatic logic [3:0] digit_val(input char_t c);
		char_t d;
		d = (c >= "A") ? c - 8'h41 + 8'd10 : c - 8'h30;  // 'A' or '0' based
		return d[3:0];
	endfunction

	// Replays the character stream through a nine-character window
	function automatic ref_t ref_model(input char_t hist[$]);
		char_t win [MON_WINDOW];  // win[0] newest
		ref_t  r;
		logic  was_ded, was_sed, was_pa, was_la, is_ded, is_sed, is_pa, is_la;
		far_t  addr;
		r = '0;
		{was_ded, was_sed, was_pa, was_la} = 4'b0;
		foreach (win[i]) win[i] = " ";
		foreach (hist[k]) begin
			for (int i = MON_WINDOW-1; i > 0; i--) win[i] = win[i-1];
			win[0] = hist[k];
			is_ded = ({win[2], win[1], win[0]} == "DED");
			is_sed = ({win[2], win[1], win[0]} == "SED");
			is_pa  = ({win[8], win[7], win[6]} == "PA ");
			is_la  = ({win[8], win[7], win[6]} == "LA ");
			addr = '0;
			for (int i = HEX_DIGITS-1; i >= 0; i--)
				addr = {addr[19:0], digit_val(win[i])};  // Oldest digit is MSB
			if (is_ded && !was_ded) r.dbl  = r.dbl + 8'd1;
			if (is_sed && !was_sed) r.sngl = r.sngl + 8'd1;
			if (is_pa && !was_pa)   r.pa   = addr;
			if (is_la && !was_la)   r.la   = addr;
			{was_ded, was_sed, was_pa, was_la} = {is_ded, is_sed, is_pa, is_la};
		end
		return r;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check_cnt(input string name, input err_cnt_t exp, input err_cnt_t act);
		if (exp !== act)
			fail_run($sformatf("MISMATCH %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_far(input string name, input far_t exp, input far_t act);
		if (exp !== act)
			fail_run($sformatf("MISMATCH %s: expected %06h, actual %06h", name, exp, act));
	endtask

	task automatic check_cmd(input string name, input cmd_t exp, input cmd_t act);
		if (exp !== act)
			fail_run($sformatf("MISMATCH %s: expected %02h, actual %02h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act)
			fail_run($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_status(input string name, input status_t exp, input status_t act);
		if (exp !== act)
			fail_run($sformatf("MISMATCH %s: expected %04h, actual %04h", name, exp, act));
	endtask

	// Checks every command the core pops while the head is stable at negedge
	always @(negedge CLK40) begin
		if (!RST && cmd_read_i && !cmd_empty_o) begin
			if (rd_idx >= exp_cmd_q.size())
				fail_run("Core read a command that was never expected in the FIFO");
			else
				check_cmd("command readout", exp_cmd_q[rd_idx], cmd_data_o);
			rd_idx++;
		end
	end

	////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////////////

	task automatic send_char(input char_t c);
		@(posedge CLK40);
		mon_txdata_i  <= c;
		mon_txwrite_i <= 1'b1;
		sent_q.push_back(c);
	endtask

	task automatic send_text(input string s);
		for (int i = 0; i < s.len(); i++) send_char(s[i]);
	endtask

	// Stop strobing and wait until the FAR registers have loaded (E+2)
	task automatic stream_settle();
		@(posedge CLK40);
		mon_txwrite_i <= 1'b0;
		repeat (2) @(posedge CLK40);
		@(negedge CLK40);
	endtask

	task automatic pulse_clear(input bit counters);
		@(posedge CLK40);
		if (counters) cnt_clr_i <= 1'b1;
		else          ded_clr_i <= 1'b1;
		@(posedge CLK40);
		cnt_clr_i <= 1'b0;
		ded_clr_i <= 1'b0;
		@(negedge CLK40);
	endtask

	task automatic take_source(input bit use_dbg);
		@(posedge CLK40);
		if (use_dbg) dbg_take_i  <= 1'b1;
		else         jtag_take_i <= 1'b1;
		@(posedge CLK40);
		dbg_take_i  <= 1'b0;
		jtag_take_i <= 1'b0;
		src_dbg = use_dbg;
	endtask

	task automatic send_cmd(input bit use_dbg, input cmd_t c);
		@(posedge CLK40);
		if (use_dbg) begin
			dbg_cmd_data_i <= c;
			dbg_send_i     <= 1'b1;
		end else begin
			jtag_cmd_data_i <= c;
			jtag_send_i     <= 1'b1;
		end
		if (use_dbg == src_dbg && model_fill < CMD_FIFO_DEPTH) begin  // Else dropped
			exp_cmd_q.push_back(c);
			model_fill++;
		end
		@(posedge CLK40);
		dbg_send_i  <= 1'b0;
		jtag_send_i <= 1'b0;
	endtask

	// Reads until the FIFO runs empty
	task automatic drain_fifo(input string name);
		bit done;
		done = 1'b0;
		@(posedge CLK40);
		cmd_read_i <= 1'b1;
		for (int n = 0; n < WAIT_MAX && !done; n++) begin
			@(negedge CLK40);
			done = cmd_empty_o;
		end
		@(posedge CLK40);
		cmd_read_i <= 1'b0;
		if (!done) fail_run({name, ": command FIFO never ran empty"});
		if (rd_idx != exp_cmd_q.size()) fail_run({name, ": not every queued command was read"});
		model_fill = 0;
	endtask

	////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////

	initial begin
		ref_t    r;
		bit      tok_ded, dbl_seen;
		int      v;
		logic    [6:0] cs;
		logic    crc;
		status_t exp_st;
		void'($urandom(4));
		{RST, mon_txwrite_i, crc_err_i, ded_clr_i, cnt_clr_i} = 5'b10000;
		{jtag_take_i, jtag_send_i, dbg_take_i, dbg_send_i, cmd_read_i} = 5'b0;
		mon_txdata_i    = 8'h00;
		core_status_i   = 7'h00;
		jtag_cmd_data_i = 8'h00;
		dbg_cmd_data_i  = 8'h00;
		model_fill      = 0;
		src_dbg         = 1'b0;
		dbl_seen        = 1'b0;
		repeat (10) @(posedge CLK40);
		RST <= 1'b0;
		@(negedge CLK40);

		// Reset state
		check_cnt("reset SED count", 8'd0, err_cnt_o[7:0]);
		check_cnt("reset DED count", 8'd0, err_cnt_o[15:8]);
		check_far("reset PA", 24'd0, far_pa_o);
		check_far("reset LA", 24'd0, far_la_o);
		check_bit("reset DED flag", 1'b0, status_o[ST_DED_BIT]);
		check_bit("reset empty", 1'b1, cmd_empty_o);

		// Error tokens between lower case filler
		for (int t = 0; t < 24; t++) begin
			tok_ded = (t == 5) || ($urandom_range(1) == 1);
			v = $urandom_range(3, 1);
			for (int k = 0; k < v; k++) send_char(8'($urandom_range(122, 97)));
			if (tok_ded) send_text("DED");
			else         send_text("SED");
			if (tok_ded && !dbl_seen) begin
				stream_settle();
				check_bit("flag after first DED", 1'b1, status_o[ST_DED_BIT]);
				dbl_seen = 1'b1;
			end
		end
		stream_settle();
		r = ref_model(sent_q);
		check_cnt("SED count", r.sngl, err_cnt_o[7:0]);
		check_cnt("DED count", r.dbl, err_cnt_o[15:8]);
		pulse_clear(1'b0);
		check_bit("flag after ded_clr", 1'b0, status_o[ST_DED_BIT]);
		pulse_clear(1'b1);
		check_cnt("SED after cnt_clr", 8'd0, err_cnt_o[7:0]);
		check_cnt("DED after cnt_clr", 8'd0, err_cnt_o[15:8]);

		// Frame addresses
		for (int t = 0; t < 6; t++) begin
			if (t[0]) send_text("LA ");
			else      send_text("PA ");
			for (int d = 0; d < HEX_DIGITS; d++) begin
				v = $urandom_range(15, 0);
				send_char((v < 10) ? 8'(48 + v) : 8'(55 + v));  // Upper case hex
			end
			send_char(" ");
			stream_settle();
			r = ref_model(sent_q);
			check_far("PA address", r.pa, far_pa_o);
			check_far("LA address", r.la, far_la_o);
		end
		pulse_clear(1'b0);
		check_far("PA after ded_clr", 24'd0, far_pa_o);
		check_far("LA after ded_clr", 24'd0, far_la_o);

		// Source switching where unselected strobes must not reach the FIFO
		for (int i = 0; i < 3; i++) send_cmd(1'b0, 8'($urandom));
		take_source(1'b1);
		for (int i = 0; i < 3; i++) begin
			send_cmd(1'b1, 8'($urandom));
			send_cmd(1'b0, 8'($urandom));
		end
		take_source(1'b0);
		for (int i = 0; i < 3; i++) begin
			send_cmd(1'b0, 8'($urandom));
			send_cmd(1'b1, 8'($urandom));
		end
		drain_fifo("source switch");

		// Overfill by one
		for (int i = 0; i < 17; i++) send_cmd(1'b0, 8'(160 + i));
		@(negedge CLK40);
		check_bit("empty with FIFO full", 1'b0, cmd_empty_o);
		drain_fifo("FIFO overflow");

		// Status packing
		for (int i = 0; i < 8; i++) begin
			cs  = 7'($urandom);
			crc = 1'($urandom);
			@(posedge CLK40);
			core_status_i <= cs;
			crc_err_i     <= crc;
			@(negedge CLK40);
			exp_st = '0;
			exp_st[6:0]        = cs;
			exp_st[ST_CRC_BIT] = crc;  // Flag cleared earlier
			check_status("status word", exp_st, status_o);
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: sem_monitor.f
design/sem_pkg.sv
design/sem_event_if.sv
design/sem_monitor_parser.sv
design/sem_error_log.sv
design/sem_cmd_queue.sv
design/sem_monitor_top.sv
tb/tb_sem_monitor.sv

// File: Makefile
SIM      = verilator
TOP      = tb_sem_monitor
FILELIST = sem_monitor.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: sim clean

# Exit status of the model is nonzero when the testbench calls $fatal
sim:
	$(SIM) $(FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
